//--- verilog/tile_pkg.sv
`default_nettype none

package tile_pkg;

  // number of tiles and the width of a core index
  localparam int NumCores = 4;
  localparam int CoreIdxW = 2;

  // data port widths, same as the core's data interface
  localparam int DataW = 32;
  localparam int AddrW = 32;
  localparam int BeW   = 4;

  // message address selects a register in the receiving core
  localparam int MsgAddrW = 5;

  // per-tile ram windows, tile n sits at RamBase0 + n * RamStride
  localparam logic [AddrW-1:0] RamBase0  = 32'h0010_0000;
  localparam logic [AddrW-1:0] RamStride = 32'h0010_0000;
  // 1 MB window
  localparam logic [AddrW-1:0] RamMask   = ~32'h000F_FFFF;
  // physical words, the window aliases onto these
  localparam int RamWords = 1024;

  // timer window, 1 kB, same address in every tile
  localparam logic [AddrW-1:0] TimerBase = 32'h0003_0000;
  localparam logic [AddrW-1:0] TimerMask = ~32'h0000_03FF;

  // timer register offsets inside the window
  localparam logic [9:0] TimerMtimeLo = 10'h000;
  localparam logic [9:0] TimerMtimeHi = 10'h004;
  localparam logic [9:0] TimerCmpLo   = 10'h008;
  localparam logic [9:0] TimerCmpHi   = 10'h00C;

  // device picked by the address decoder
  typedef enum logic [1:0] {
    DevRam,
    DevTimer,
    DevNone
  } bus_dev_e;

  // one data port access as the core presents it
  typedef struct packed {
    logic             we;
    logic [BeW-1:0]   be;
    logic [AddrW-1:0] addr;
    logic [DataW-1:0] wdata;
  } bus_req_t;

  // response returned with rvalid
  typedef struct packed {
    logic [DataW-1:0] rdata;
    logic             err;
  } bus_rsp_t;

  // message as offered by a sender
  typedef struct packed {
    logic [CoreIdxW-1:0] dest;
    logic [MsgAddrW-1:0] addr;
    logic [DataW-1:0]    data;
  } msg_t;

  // message as seen by the receiver
  typedef struct packed {
    logic [CoreIdxW-1:0] src;
    logic [MsgAddrW-1:0] addr;
    logic [DataW-1:0]    data;
  } msg_rx_t;

endpackage

`default_nettype wire

//--- verilog/tile_bus.sv
`timescale 1ns/10ps
`default_nettype none

module tile_bus #(
  parameter int TileIdx = 0
) (
  input  logic                          clk_sys,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  tile_pkg::bus_req_t            req_data_i,
  input  logic [tile_pkg::DataW-1:0]    ram_rdata_i,
  input  logic [tile_pkg::DataW-1:0]    timer_rdata_i,
  output logic                          ram_sel_o,
  output logic                          timer_sel_o,
  output logic                          rvalid_o,
  output tile_pkg::bus_rsp_t            rsp_o
);

  import tile_pkg::*;

  logic [AddrW-1:0] ram_base;
  bus_dev_e         dev;
  bus_dev_e         dev_q;
  logic             rvalid_q;

  // base of this tile's own ram window
  assign ram_base = RamBase0 + AddrW'(TileIdx) * RamStride;

  // base/mask decode, ram wins if windows ever overlapped
  always_comb begin
    if ((req_data_i.addr & RamMask) == ram_base) begin
      dev = DevRam;
    end else if ((req_data_i.addr & TimerMask) == TimerBase) begin
      dev = DevTimer;
    end else begin
      dev = DevNone;
    end
  end

  // grant equals req, so a request is an access right away
  assign ram_sel_o   = req_i && (dev == DevRam);
  assign timer_sel_o = req_i && (dev == DevTimer);

  // one stage return pipeline, remembers who answers next cycle
  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      dev_q    <= DevNone;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        dev_q <= dev;
      end
    end
  end

  assign rvalid_o = rvalid_q;

  // response mux, unmapped addresses give err with zero data
  always_comb begin
    rsp_o = '0;
    case (dev_q)
      DevRam:   rsp_o.rdata = ram_rdata_i;
      DevTimer: rsp_o.rdata = timer_rdata_i;
      default:  rsp_o.err   = 1'b1;
    endcase
  end

  // ram and timer windows must never both claim an access
  a_one_sel : assert property (@(posedge clk_sys) disable iff (reset_i)
    ram_sel_o |-> ((req_data_i.addr & TimerMask) != TimerBase));

endmodule

`default_nettype wire

//--- verilog/tile_ram.sv
`timescale 1ns/10ps
`default_nettype none

module tile_ram (
  input  logic                       clk_sys,
  input  logic                       sel_i,
  input  tile_pkg::bus_req_t         req_data_i,
  output logic [tile_pkg::DataW-1:0] rdata_o
);

  import tile_pkg::*;

  logic [DataW-1:0]            mem [RamWords];
  logic [$clog2(RamWords)-1:0] word_idx;

  // word index, upper window bits are ignored so the 1 MB window aliases
  assign word_idx = req_data_i.addr[$clog2(RamWords)+1:2];

  always_ff @(posedge clk_sys) begin
    if (sel_i) begin
      if (req_data_i.we) begin
        // byte lanes written only where be is set
        for (int b = 0; b < BeW; b++) begin
          if (req_data_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end else begin
        // read data valid the next cycle, held until the next read
        rdata_o <= mem[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/tile_timer.sv
`timescale 1ns/10ps
`default_nettype none

module tile_timer (
  input  logic                       clk_sys,
  input  logic                       reset_i,
  input  logic                       sel_i,
  input  tile_pkg::bus_req_t         req_data_i,
  output logic [tile_pkg::DataW-1:0] rdata_o,
  output logic                       irq_o
);

  import tile_pkg::*;

  logic [2*DataW-1:0] mtime_q;
  logic [2*DataW-1:0] mtimecmp_q;
  logic               irq_q;
  logic [9:0]         reg_off;
  logic               wr;

  // merge a write into a 32 bit half by byte enable
  function automatic logic [DataW-1:0] be_merge(input logic [DataW-1:0] old_w,
                                                input logic [DataW-1:0] new_w,
                                                input logic [BeW-1:0]   be);
    logic [DataW-1:0] res;
    res = old_w;
    for (int b = 0; b < BeW; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // word aligned offset inside the 1 kB window
  assign reg_off = {req_data_i.addr[9:2], 2'b00};
  assign wr      = sel_i && req_data_i.we;

  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      // free running count, a write below overrides the written half
      mtime_q <= mtime_q + 1'b1;
      if (wr) begin
        case (reg_off)
          TimerMtimeLo: mtime_q[DataW-1:0] <=
              be_merge(mtime_q[DataW-1:0], req_data_i.wdata, req_data_i.be);
          TimerMtimeHi: mtime_q[2*DataW-1:DataW] <=
              be_merge(mtime_q[2*DataW-1:DataW], req_data_i.wdata, req_data_i.be);
          TimerCmpLo: mtimecmp_q[DataW-1:0] <=
              be_merge(mtimecmp_q[DataW-1:0], req_data_i.wdata, req_data_i.be);
          TimerCmpHi: mtimecmp_q[2*DataW-1:DataW] <=
              be_merge(mtimecmp_q[2*DataW-1:DataW], req_data_i.wdata, req_data_i.be);
          default: ;
        endcase
      end
      // level irq, compare registered once
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // read mux, other offsets read as zero
  always_ff @(posedge clk_sys) begin
    if (sel_i && !req_data_i.we) begin
      case (reg_off)
        TimerMtimeLo: rdata_o <= mtime_q[DataW-1:0];
        TimerMtimeHi: rdata_o <= mtime_q[2*DataW-1:DataW];
        TimerCmpLo:   rdata_o <= mtimecmp_q[DataW-1:0];
        TimerCmpHi:   rdata_o <= mtimecmp_q[2*DataW-1:DataW];
        default:      rdata_o <= '0;
      endcase
    end
  end

  assign irq_o = irq_q;

  // compare starts from all ones, so no irq right out of reset
  a_irq_after_reset : assert property (@(posedge clk_sys)
    $fell(reset_i) |=> !irq_o);

endmodule

`default_nettype wire

//--- verilog/msg_router.sv
`timescale 1ns/10ps
`default_nettype none

module msg_router (
  input  logic                                          clk_sys,
  input  logic                                          reset_i,
  input  logic [tile_pkg::NumCores-1:0]                 req_i,
  input  tile_pkg::msg_t [tile_pkg::NumCores-1:0]       msg_i,
  output logic [tile_pkg::NumCores-1:0]                 gnt_o,
  output logic [tile_pkg::NumCores-1:0]                 valid_o,
  output tile_pkg::msg_rx_t [tile_pkg::NumCores-1:0]    msg_o
);

  import tile_pkg::*;

  logic [NumCores-1:0] req_live;
  logic [NumCores-1:0] gnt_q;
  logic [NumCores-1:0] valid_q;
  logic [CoreIdxW-1:0] ptr_q;
  logic [CoreIdxW-1:0] win_idx;
  logic                win_valid;
  msg_rx_t             rx_q;

  // a core whose grant is pulsing still holds req this cycle, skip it
  assign req_live = req_i & ~gnt_q;

  // round robin, first live request at or after the pointer
  // scanning down so the closest one to ptr is the last hit
  always_comb begin
    int cand;
    win_valid = 1'b0;
    win_idx   = ptr_q;
    for (int k = NumCores - 1; k >= 0; k--) begin
      cand = (int'(ptr_q) + k) % NumCores;
      if (req_live[cand]) begin
        win_valid = 1'b1;
        win_idx   = CoreIdxW'(cand);
      end
    end
  end

  always_ff @(posedge clk_sys) begin
    if (reset_i) begin
      ptr_q   <= '0;
      gnt_q   <= '0;
      valid_q <= '0;
    end else begin
      gnt_q   <= '0;
      valid_q <= '0;
      if (win_valid) begin
        // grant to sender and delivery to dest pulse together
        gnt_q[win_idx]               <= 1'b1;
        valid_q[msg_i[win_idx].dest] <= 1'b1;
        // next search starts just past the winner
        ptr_q <= CoreIdxW'((int'(win_idx) + 1) % NumCores);
      end
    end
  end

  // payload register, qualified by valid_o
  always_ff @(posedge clk_sys) begin
    if (win_valid) begin
      rx_q.src  <= win_idx;
      rx_q.addr <= msg_i[win_idx].addr;
      rx_q.data <= msg_i[win_idx].data;
    end
  end

  assign gnt_o   = gnt_q;
  assign valid_o = valid_q;
  // same payload to every receiver, only dest sees valid
  assign msg_o   = {NumCores{rx_q}};

  // a waiting sender is served within one full round robin turn
  for (genvar i = 0; i < NumCores; i++) begin : g_fair
    a_rr_bound : assert property (@(posedge clk_sys) disable iff (reset_i)
      req_i[i] && !gnt_o[i] |-> ##[1:NumCores] gnt_o[i]);
  end

endmodule

`default_nettype wire

//--- verilog/multicore_system.sv
`timescale 1ns/10ps
`default_nettype none

module multicore_system (
  input  logic                                         clk_sys,
  input  logic                                         reset_i,
  input  logic [tile_pkg::NumCores-1:0]                bus_req_i,
  input  tile_pkg::bus_req_t [tile_pkg::NumCores-1:0]  bus_req_data_i,
  output logic [tile_pkg::NumCores-1:0]                bus_rvalid_o,
  output tile_pkg::bus_rsp_t [tile_pkg::NumCores-1:0]  bus_rsp_o,
  output logic [tile_pkg::NumCores-1:0]                timer_irq_o,
  input  logic [tile_pkg::NumCores-1:0]                msg_req_i,
  input  tile_pkg::msg_t [tile_pkg::NumCores-1:0]      msg_i,
  output logic [tile_pkg::NumCores-1:0]                msg_gnt_o,
  output logic [tile_pkg::NumCores-1:0]                msg_valid_o,
  output tile_pkg::msg_rx_t [tile_pkg::NumCores-1:0]   msg_o
);

  import tile_pkg::*;

  logic [NumCores-1:0] ram_sel;
  logic [NumCores-1:0] timer_sel;
  logic [DataW-1:0]    ram_rdata [NumCores];
  logic [DataW-1:0]    timer_rdata [NumCores];

  // one tile per core data port
  for (genvar c = 0; c < NumCores; c++) begin : g_tiles

    tile_bus #(
      .TileIdx (c)
    ) u_bus (
      .clk_sys       (clk_sys),
      .reset_i       (reset_i),
      .req_i         (bus_req_i[c]),
      .req_data_i    (bus_req_data_i[c]),
      .ram_rdata_i   (ram_rdata[c]),
      .timer_rdata_i (timer_rdata[c]),
      .ram_sel_o     (ram_sel[c]),
      .timer_sel_o   (timer_sel[c]),
      .rvalid_o      (bus_rvalid_o[c]),
      .rsp_o         (bus_rsp_o[c])
    );

    tile_ram u_ram (
      .clk_sys    (clk_sys),
      .sel_i      (ram_sel[c]),
      .req_data_i (bus_req_data_i[c]),
      .rdata_o    (ram_rdata[c])
    );

    // every tile brings out its own timer irq
    tile_timer u_timer (
      .clk_sys    (clk_sys),
      .reset_i    (reset_i),
      .sel_i      (timer_sel[c]),
      .req_data_i (bus_req_data_i[c]),
      .rdata_o    (timer_rdata[c]),
      .irq_o      (timer_irq_o[c])
    );

  end

  // shared core to core message network
  msg_router u_msg_router (
    .clk_sys (clk_sys),
    .reset_i (reset_i),
    .req_i   (msg_req_i),
    .msg_i   (msg_i),
    .gnt_o   (msg_gnt_o),
    .valid_o (msg_valid_o),
    .msg_o   (msg_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_multicore_system.sv
`timescale 1ns/10ps
`default_nettype none

module tb_multicore_system;

  import tile_pkg::*;

  localparam int NumOffs = 8;

  logic                          clk_sys;
  logic                          reset_i;
  logic [NumCores-1:0]           bus_req;
  bus_req_t [NumCores-1:0]       bus_req_data;
  logic [NumCores-1:0]           bus_rvalid;
  bus_rsp_t [NumCores-1:0]       bus_rsp;
  logic [NumCores-1:0]           timer_irq;
  logic [NumCores-1:0]           msg_req;
  msg_t [NumCores-1:0]           msg_in;
  logic [NumCores-1:0]           msg_gnt;
  logic [NumCores-1:0]           msg_valid;
  msg_rx_t [NumCores-1:0]        msg_out;

  logic [31:0]      rng_state = 32'h3c26;
  int               err_count = 0;
  int               tests_pass = 0;
  int               tests_fail = 0;
  // expected round robin pointer, moves past each winner
  int               rr_ptr = 0;
  logic [19:0]      offs [NumOffs];
  // expected ram contents, per tile, indexed by the aliased word
  logic [DataW-1:0] model [NumCores][RamWords];

  multicore_system i_dut (
    .clk_sys        (clk_sys),
    .reset_i        (reset_i),
    .bus_req_i      (bus_req),
    .bus_req_data_i (bus_req_data),
    .bus_rvalid_o   (bus_rvalid),
    .bus_rsp_o      (bus_rsp),
    .timer_irq_o    (timer_irq),
    .msg_req_i      (msg_req),
    .msg_i          (msg_in),
    .msg_gnt_o      (msg_gnt),
    .msg_valid_o    (msg_valid),
    .msg_o          (msg_out)
  );

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // byte lane merge of a write into the model
  function automatic logic [31:0] apply_be(input logic [31:0] old_w, input logic [31:0] new_w,
                                           input logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected rdata %h err %b, actual rdata %h err %b",
               $time, name, exp.rdata, exp.err, act.rdata, act.err);
      err_count++;
    end
  endtask

  task automatic check_msg(input string name, input msg_rx_t exp, input msg_rx_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected src %0d addr %h data %h, actual src %0d addr %h data %h",
               $time, name, exp.src, exp.addr, exp.data, act.src, act.addr, act.data);
      err_count++;
    end
  endtask

  // one result line per test
  task automatic finish_test(input string name, input int start);
    if (err_count == start) begin
      tests_pass++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_fail++;
      $display("[%0t] %s: %0d errors", $time, name, err_count - start);
    end
  endtask

  // single access, called on a falling edge, response due one cycle later
  task automatic bus_access(input int c, input logic w_en, input logic [3:0] be,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output bus_rsp_t rsp);
    bus_req[c]      = 1'b1;
    bus_req_data[c] = '{we: w_en, be: be, addr: addr, wdata: wdata};
    @(negedge clk_sys);
    check_bit("bus_rvalid_o", 1'b1, bus_rvalid[c]);
    rsp        = bus_rsp[c];
    bus_req[c] = 1'b0;
  endtask

  // read back every offset of every tile against the model
  task automatic verify_ram();
    bus_rsp_t rsp;
    bus_rsp_t exp;
    for (int c = 0; c < NumCores; c++) begin
      for (int i = 0; i < NumOffs; i++) begin
        bus_access(c, 1'b0, 4'h0, RamBase0 + c * RamStride + offs[i], 32'h0, rsp);
        exp.rdata = model[c][(offs[i] >> 2) % RamWords];
        exp.err   = 1'b0;
        check_rsp("bus_rsp_o", exp, rsp);
      end
      // no stray response once the port goes idle
      @(negedge clk_sys);
      check_bit("bus_rvalid_o idle", 1'b0, bus_rvalid[c]);
    end
  endtask

  task automatic test_reset_state();
    int start;
    start = err_count;
    for (int c = 0; c < NumCores; c++) begin
      check_bit("bus_rvalid_o", 1'b0, bus_rvalid[c]);
      check_bit("timer_irq_o", 1'b0, timer_irq[c]);
      check_bit("msg_gnt_o", 1'b0, msg_gnt[c]);
      check_bit("msg_valid_o", 1'b0, msg_valid[c]);
    end
    finish_test("reset_state", start);
  endtask

  // same offsets in every tile, different data, so tiles stay independent
  task automatic test_ram();
    int          start;
    int          idx;
    bus_rsp_t    rsp;
    logic [31:0] r;
    logic [31:0] d;
    start = err_count;
    for (int i = 0; i < NumOffs; i++) begin
      r       = next_rand();
      offs[i] = r[19:0] & 20'hFFFFC;
    end
    for (int c = 0; c < NumCores; c++) begin
      for (int i = 0; i < NumOffs; i++) begin
        idx = (offs[i] >> 2) % RamWords;
        d   = next_rand();
        bus_access(c, 1'b1, 4'hF, RamBase0 + c * RamStride + offs[i], d, rsp);
        check_bit("bus_rsp_o.err", 1'b0, rsp.err);
        model[c][idx] = d;
        // about half the words get a partial overwrite
        r = next_rand();
        if (r[0]) begin
          d = next_rand();
          bus_access(c, 1'b1, r[7:4], RamBase0 + c * RamStride + offs[i], d, rsp);
          model[c][idx] = apply_be(model[c][idx], d, r[7:4]);
        end
      end
    end
    verify_ram();
    finish_test("ram_per_tile", start);
  endtask

  task automatic test_decode_err();
    int          start;
    bus_rsp_t    rsp;
    bus_rsp_t    exp;
    logic [31:0] r;
    logic [31:0] addrs [3];
    start     = err_count;
    exp.rdata = '0;
    exp.err   = 1'b1;
    for (int c = 0; c < NumCores; c++) begin
      r        = next_rand();
      // neighbour window, old sim control window, far unmapped space
      addrs[0] = RamBase0 + ((c + 1) % NumCores) * RamStride + offs[r[2:0]];
      addrs[1] = 32'h0002_0000;
      addrs[2] = {4'hF, r[29:4], 2'b00};
      for (int a = 0; a < 3; a++) begin
        bus_access(c, 1'b1, 4'hF, addrs[a], next_rand(), rsp);
        check_bit("bus_rsp_o.err", 1'b1, rsp.err);
        bus_access(c, 1'b0, 4'h0, addrs[a], 32'h0, rsp);
        check_rsp("bus_rsp_o", exp, rsp);
      end
    end
    // rejected writes must leave every tile untouched
    verify_ram();
    finish_test("decode_err", start);
  endtask

  task automatic test_timer();
    int          start;
    int          gap;
    int          cyc;
    bus_rsp_t    rsp;
    logic [31:0] m0;
    logic [31:0] m1;
    start = err_count;
    for (int c = 0; c < NumCores; c++) begin
      check_bit("timer_irq_o", 1'b0, timer_irq[c]);
      bus_access(c, 1'b0, 4'h0, TimerBase + TimerMtimeLo, 32'h0, rsp);
      m0  = rsp.rdata;
      gap = 3 + next_rand() % 10;
      repeat (gap) @(negedge clk_sys);
      bus_access(c, 1'b0, 4'h0, TimerBase + TimerMtimeLo, 32'h0, rsp);
      check_bit("bus_rsp_o.err", 1'b0, rsp.err);
      m1 = rsp.rdata;
      // the two reads are sampled gap + 1 rising edges apart
      check_bit("mtime advance", 1'b1, (m1 - m0) >= gap + 1);
      // compare 40 ticks ahead
      bus_access(c, 1'b1, 4'hF, TimerBase + TimerCmpLo, m1 + 40, rsp);
      bus_access(c, 1'b1, 4'hF, TimerBase + TimerCmpHi, 32'h0, rsp);
      cyc = 0;
      while (!timer_irq[c] && cyc < 100) begin
        @(negedge clk_sys);
        cyc++;
      end
      if (!timer_irq[c]) begin
        $display("timer interrupt of core %0d never rose", c);
        err_count++;
      end
      bus_access(c, 1'b1, 4'hF, TimerBase + TimerCmpLo, 32'hFFFF_FFFF, rsp);
      bus_access(c, 1'b1, 4'hF, TimerBase + TimerCmpHi, 32'hFFFF_FFFF, rsp);
      cyc = 0;
      while (timer_irq[c] && cyc < 10) begin
        @(negedge clk_sys);
        cyc++;
      end
      if (timer_irq[c]) begin
        $display("timer interrupt of core %0d did not clear", c);
        err_count++;
      end
    end
    finish_test("timer", start);
  endtask

  task automatic test_single_msg();
    int          start;
    int          src;
    int          dest;
    bit          got;
    msg_rx_t     exp;
    start = err_count;
    repeat (4) begin
      src      = next_rand() % NumCores;
      dest     = next_rand() % NumCores;
      exp.src  = src;
      exp.addr = next_rand();
      exp.data = next_rand();
      msg_req[src] = 1'b1;
      msg_in[src]  = '{dest: dest, addr: exp.addr, data: exp.data};
      got = 1'b0;
      for (int cyc = 0; cyc < 8 && !got; cyc++) begin
        @(negedge clk_sys);
        if (msg_gnt[src]) begin
          got = 1'b1;
          for (int k = 0; k < NumCores; k++) begin
            check_bit("msg_gnt_o", k == src, msg_gnt[k]);
            check_bit("msg_valid_o", k == dest, msg_valid[k]);
          end
          check_msg("msg_o", exp, msg_out[dest]);
        end
      end
      msg_req[src] = 1'b0;
      if (!got) begin
        $display("message from core %0d was never granted", src);
        err_count++;
      end
      rr_ptr = (src + 1) % NumCores;
      @(negedge clk_sys);
    end
    finish_test("single_msg", start);
  endtask

  // all cores at once, destinations rotated so they stay distinct
  task automatic test_contention();
    int      start;
    int      rot;
    int      order;
    int      w;
    msg_rx_t exp [NumCores];
    int      dest [NumCores];
    start = err_count;
    repeat (2) begin
      rot = next_rand() % NumCores;
      for (int c = 0; c < NumCores; c++) begin
        dest[c]     = (c + rot) % NumCores;
        exp[c].src  = c;
        exp[c].addr = next_rand();
        exp[c].data = next_rand();
        msg_req[c]  = 1'b1;
        msg_in[c]   = '{dest: dest[c], addr: exp[c].addr, data: exp[c].data};
      end
      order = 0;
      for (int cyc = 0; cyc < NumCores + 1 && order < NumCores; cyc++) begin
        @(negedge clk_sys);
        check_bit("msg_valid_o one-hot", 1'b1, $onehot0(msg_valid));
        if (msg_gnt != '0) begin
          w = (rr_ptr + order) % NumCores;
          for (int k = 0; k < NumCores; k++) begin
            check_bit("msg_gnt_o", k == w, msg_gnt[k]);
            check_bit("msg_valid_o", k == dest[w], msg_valid[k]);
          end
          check_msg("msg_o", exp[w], msg_out[dest[w]]);
          msg_req[w] = 1'b0;
          order++;
        end
      end
      if (order < NumCores) begin
        $display("only %0d of %0d contending messages were granted", order, NumCores);
        err_count++;
      end
      rr_ptr  = (rr_ptr + order) % NumCores;
      msg_req = '0;
      repeat (2) @(negedge clk_sys);
    end
    finish_test("contention", start);
  endtask

  initial begin
    reset_i      = 1'b1;
    bus_req      = '0;
    bus_req_data = '0;
    msg_req      = '0;
    msg_in       = '0;
    repeat (5) @(negedge clk_sys);
    reset_i = 1'b0;
    test_reset_state();
    test_ram();
    test_decode_err();
    test_timer();
    test_single_msg();
    test_contention();
    $display("tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_count);
    if (tests_fail == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
verilog/tile_pkg.sv
verilog/tile_bus.sv
verilog/tile_ram.sv
verilog/tile_timer.sv
verilog/msg_router.sv
verilog/multicore_system.sv
testbench/tb_multicore_system.sv

//--- Bender.yml
package:
  name: multicore_system

sources:
  - verilog/tile_pkg.sv
  - verilog/tile_bus.sv
  - verilog/tile_ram.sv
  - verilog/tile_timer.sv
  - verilog/msg_router.sv
  - verilog/multicore_system.sv
  - target: test
    files:
      - testbench/tb_multicore_system.sv
